// ==== aluFlags.sv ====
// ALU, flags and jump tester
`timescale 1ns/1ps
`default_nettype none

module aluFlags (
  input  logic          clock,
  input  logic          rstN,
  input  cpuPkg::ctrlT  ctrl,
  input  cpuPkg::wordT  opA,
  input  cpuPkg::wordT  opB,
  output cpuPkg::wordT  result,
  output cpuPkg::flagsT flags,
  output logic          takeJump
);
  import cpuPkg::*;

  wordT  opBSel;
  logic  carryOut;
  logic  ovfOut;
  flagsT flagReg;
  logic  flagBit;

  assign opBSel = ctrl.useImm ? ctrl.immediate : opB;

  always_comb begin
    carryOut = 1'b0;
    ovfOut   = 1'b0;
    unique case (ctrl.aluOp)
      aluAdd: begin
        {carryOut, result} = {1'b0, opA} + {1'b0, opBSel};
        ovfOut = (opA[15] == opBSel[15]) && (result[15] != opA[15]);
      end
      aluSub: begin
        {carryOut, result} = {1'b0, opA} - {1'b0, opBSel}; // Carry is borrow
        ovfOut = (opA[15] != opBSel[15]) && (result[15] != opA[15]);
      end
      aluAnd:    result = opA & opBSel;
      aluOr:     result = opA | opBSel;
      aluXor:    result = opA ^ opBSel;
      aluNot:    result = ~opA;
      aluShl:    {carryOut, result} = {opA, 1'b0};
      aluShr:    {result, carryOut} = {1'b0, opA};
      aluPassB:  result = opBSel;
      aluByteLo: result = {opA[15:8], opBSel[7:0]};
      aluByteHi: result = {opBSel[7:0], opA[7:0]};
      default:   result = opA; // passA, load and store address
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rstN) begin
      flagReg <= '0;
    end else if (ctrl.flagWe) begin
      flagReg.zero     <= (result == '0);
      flagReg.negative <= result[15];
      flagReg.carry    <= carryOut;
      flagReg.overflow <= ovfOut;
    end
  end

  always_comb begin
    flags            = flagReg;
    flags.alwaysTrue = 1'b1;
  end

  always_comb begin
    unique case (ctrl.cond)
      condZero:     flagBit = flags.zero;
      condNeg:      flagBit = flags.negative;
      condCarry:    flagBit = flags.carry;
      condOverflow: flagBit = flags.overflow;
      condAlways:   flagBit = flags.alwaysTrue;
      default:      flagBit = 1'b0;
    endcase
    // Unknown codes and code 15 never jump
    takeJump = (ctrl.cond <= condAlways) && (flagBit == ctrl.jumpPolarity);
  end

  assert property (@(posedge clock) disable iff (!rstN)
    ctrl.flagWe |-> !(ctrl.aluOp inside {aluLoad, aluStore}));

endmodule

`default_nettype wire

// ==== build.f ====
cpuPkg.sv
controlFsm.sv
pcCounter.sv
regFile.sv
aluFlags.sv
progMem.sv
dataMem.sv
cpuTop.sv
tbCpu.sv

// ==== controlFsm.sv ====
// Control unit FSM and decoder
`timescale 1ns/1ps
`default_nettype none

module controlFsm (
  input  logic          clock,
  input  logic          rstN,
  input  logic          run,
  input  cpuPkg::wordT  instr,
  output cpuPkg::stateT state,
  output cpuPkg::ctrlT  ctrl
);
  import cpuPkg::*;

  stateT nextState;
  ctrlT  dec;      // Decoded fields without strobes
  logic  wantReg;  // Instruction writes a register
  logic  wantMem;  // Store
  logic  wantFlag; // ALU op that updates flags
  condT  condCode;

  always_ff @(posedge clock) begin
    if (!rstN) begin
      state <= fetchS;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    unique case (state)
      fetchS:     nextState = run ? decodeS : fetchS; // Held here while run is low
      decodeS:    nextState = executeS;
      executeS:   nextState = writebackS;
      default:    nextState = fetchS;
    endcase
  end

  always_comb begin
    dec          = '0;
    dec.aluOp    = aluPassA;
    dec.wbSel    = wbAlu;
    dec.cond     = condNone;
    wantReg      = 1'b0;
    wantMem      = 1'b0;
    wantFlag     = 1'b0;
    condCode     = condNone;
    if (state != fetchS) begin
      unique case (fmtT'(instr[15:14]))
        fmtAlu: begin
          dec.selDest = instr[13:11];
          dec.selA    = instr[5:3];
          dec.selB    = instr[2:0];
          dec.aluOp   = aluOpT'(instr[10:6]);
          if (instr[10:6] == aluStore) begin
            wantMem = 1'b1;
          end else if (instr[10:6] == aluLoad) begin
            wantReg   = 1'b1;
            dec.wbSel = wbMem;
          end else begin
            wantReg  = 1'b1;
            wantFlag = 1'b1;
          end
        end
        fmtConst: begin
          dec.selDest   = instr[13:11];
          dec.immediate = {{5{instr[10]}}, instr[10:0]}; // Sign-extended 11 bits
          dec.wbSel     = wbConst;
          wantReg       = 1'b1;
        end
        fmtByte: begin
          dec.selDest   = instr[13:11];
          dec.selA      = instr[13:11]; // Old value keeps the other half
          dec.immediate = {8'h00, instr[7:0]};
          dec.useImm    = 1'b1;
          dec.aluOp     = instr[10] ? aluByteHi : aluByteLo;
          wantReg       = 1'b1;
        end
        default: begin
          unique case (jmpT'(instr[13:12]))
            jmpFalse, jmpTrue: begin
              dec.jumpEn       = 1'b1;
              dec.jumpPolarity = instr[12];
              dec.immediate    = {{8{instr[7]}}, instr[7:0]};
              condCode         = instr[11:8];
            end
            jmpAlways: begin
              dec.jumpEn       = 1'b1;
              dec.jumpPolarity = 1'b1;
              dec.immediate    = {{4{instr[11]}}, instr[11:0]};
              condCode         = condAlways; // Evaluated like a taken condition
            end
            default: begin
              dec.jumpReg = 1'b1;
              dec.selB    = instr[2:0];
              if (!instr[11]) begin // Link into r7
                dec.selDest = 3'd7;
                dec.wbSel   = wbPcInc;
                wantReg     = 1'b1;
              end
            end
          endcase
        end
      endcase
    end
  end

  // Strobes follow the state
  always_comb begin
    ctrl       = dec;
    ctrl.fetch = (state == fetchS) && run;
    if (state == executeS) begin
      ctrl.flagWe = wantFlag;
      ctrl.cond   = condCode;
    end
    if (state == writebackS) begin
      ctrl.regWe = wantReg;
      ctrl.memWe = wantMem;
      ctrl.pcInc = 1'b1;
    end
  end

  // Instruction word holds until the instruction ends
  assert property (@(posedge clock) disable iff (!rstN)
    state inside {executeS, writebackS} |-> $stable(instr));

endmodule

`default_nettype wire

// ==== cpuPkg.sv ====
// CPU shared types
`default_nettype none

package cpuPkg;

  typedef logic [15:0] wordT;    // Data and instruction word
  typedef logic [2:0]  regAddrT; // Register index
  typedef logic [3:0]  condT;    // Jump condition code

  // Condition codes, 0 to 4 pick a flag
  localparam condT condZero     = 4'd0;
  localparam condT condNeg      = 4'd1;
  localparam condT condCarry    = 4'd2;
  localparam condT condOverflow = 4'd3;
  localparam condT condAlways   = 4'd4;
  localparam condT condNone     = 4'd15; // Never jumps

  typedef struct packed {
    logic zero;
    logic negative;
    logic carry;
    logic overflow;
    logic alwaysTrue;
  } flagsT;

  // Instruction format, bits 15:14
  typedef enum logic [1:0] {
    fmtJump  = 2'b00,
    fmtConst = 2'b01,
    fmtAlu   = 2'b10,
    fmtByte  = 2'b11
  } fmtT;

  // Jump kind, bits 13:12 of a format-00 word
  typedef enum logic [1:0] {
    jmpFalse  = 2'b00,
    jmpTrue   = 2'b01,
    jmpAlways = 2'b10,
    jmpLink   = 2'b11 // Bit 11 low links, high is a plain register jump
  } jmpT;

  typedef enum logic [4:0] {
    aluAdd    = 5'b00000,
    aluSub    = 5'b00001,
    aluAnd    = 5'b00010,
    aluOr     = 5'b00011,
    aluXor    = 5'b00100,
    aluNot    = 5'b00101,
    aluShl    = 5'b00110,
    aluShr    = 5'b00111,
    aluPassA  = 5'b01000,
    aluPassB  = 5'b01001,
    aluLoad   = 5'b01010,
    aluStore  = 5'b01011,
    aluByteLo = 5'b01100, // Byte constant into low half
    aluByteHi = 5'b01101  // Byte constant into high half
  } aluOpT;

  typedef enum logic [1:0] {
    fetchS     = 2'b00,
    decodeS    = 2'b01,
    executeS   = 2'b10,
    writebackS = 2'b11
  } stateT;

  typedef enum logic [1:0] {
    wbAlu   = 2'b00,
    wbPcInc = 2'b01,
    wbMem   = 2'b10,
    wbConst = 2'b11
  } wbSelT;

  typedef struct packed {
    regAddrT selA;
    regAddrT selB;
    regAddrT selDest;
    logic    regWe;
    logic    memWe;
    logic    flagWe;
    logic    fetch;        // Instruction register load
    logic    pcInc;
    logic    jumpEn;
    logic    jumpPolarity; // High jumps on a set flag
    logic    jumpReg;
    condT    cond;
    aluOpT   aluOp;
    wbSelT   wbSel;
    wordT    immediate;
    logic    useImm;
  } ctrlT;

endpackage

`default_nettype wire

// ==== cpuTop.sv ====
// Multicycle CPU top level
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
  parameter int progDepth = 256,
  parameter int dataDepth = 256
) (
  input  logic            clock,
  input  logic            rstN,
  input  logic            run,
  input  logic            progWe,
  input  cpuPkg::wordT    progAddr,
  input  cpuPkg::wordT    progData,
  output cpuPkg::wordT    pc,
  output cpuPkg::stateT   state,
  output logic            regWe,
  output cpuPkg::regAddrT regAddr,
  output cpuPkg::wordT    regData
);
  import cpuPkg::*;

  ctrlT ctrl;
  wordT instr;
  wordT rdA;
  wordT rdB;
  wordT aluResult;
  wordT memRd;
  wordT wbData;
  logic takeJump;

  controlFsm uCtrl (
    .clock, .rstN, .run, .instr, .state, .ctrl
  );

  pcCounter #(.progDepth(progDepth)) uPc (
    .clock, .rstN, .ctrl, .takeJump, .regB(rdB), .pc
  );

  progMem #(.progDepth(progDepth)) uProg (
    .clock, .we(progWe), .wrAddr(progAddr), .wrData(progData),
    .rdAddr(pc), .fetch(ctrl.fetch), .instr
  );

  regFile uRegs (
    .clock, .rstN, .selA(ctrl.selA), .selB(ctrl.selB), .wrAddr(ctrl.selDest),
    .we(ctrl.regWe), .wrData(wbData), .rdA, .rdB
  );

  aluFlags uAlu (
    .clock, .rstN, .ctrl, .opA(rdA), .opB(rdB),
    .result(aluResult), .flags(), .takeJump
  );

  dataMem #(.dataDepth(dataDepth)) uData (
    .clock, .we(ctrl.memWe), .addr(rdA), .wrData(rdB), .rdData(memRd)
  );

  // Writeback source
  always_comb begin
    unique case (ctrl.wbSel)
      wbPcInc: wbData = pc + 16'd1; // Link address
      wbMem:   wbData = memRd;
      wbConst: wbData = ctrl.immediate;
      default: wbData = aluResult;
    endcase
  end

  assign regWe   = ctrl.regWe;
  assign regAddr = ctrl.selDest;
  assign regData = wbData;

endmodule

`default_nettype wire

// ==== dataMem.sv ====
// Data memory
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
  parameter int dataDepth = 256
) (
  input  logic         clock,
  input  logic         we,
  input  cpuPkg::wordT addr,
  input  cpuPkg::wordT wrData,
  output cpuPkg::wordT rdData
);
  import cpuPkg::*;

  localparam int addrW = $clog2(dataDepth);

  wordT mem [dataDepth];

  always_ff @(posedge clock) begin
    if (we) begin
      mem[addr[addrW-1:0]] <= wrData;
    end
  end

  assign rdData = mem[addr[addrW-1:0]]; // Address wraps at depth

endmodule

`default_nettype wire

// ==== pcCounter.sv ====
// Program counter
`timescale 1ns/1ps
`default_nettype none

module pcCounter #(
  parameter int progDepth = 256
) (
  input  logic         clock,
  input  logic         rstN,
  input  cpuPkg::ctrlT ctrl,
  input  logic         takeJump,
  input  cpuPkg::wordT regB,
  output cpuPkg::wordT pc
);
  import cpuPkg::*;

  logic jumpLatched; // Condition outcome from executeS
  wordT target;

  always_ff @(posedge clock) begin
    if (!rstN) begin
      jumpLatched <= 1'b0;
    end else begin
      jumpLatched <= takeJump;
    end
  end

  always_comb begin
    if (ctrl.jumpReg) begin
      target = regB;
    end else if (ctrl.jumpEn && jumpLatched) begin
      target = pc + ctrl.immediate; // Signed offset
    end else begin
      target = pc + 16'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (!rstN) begin
      pc <= '0;
    end else if (ctrl.pcInc) begin
      pc <= wordT'(target % progDepth);
    end
  end

  // Register jumps never combine with a relative jump
  assert property (@(posedge clock) disable iff (!rstN) !(ctrl.jumpReg && ctrl.jumpEn));

endmodule

`default_nettype wire

// ==== progMem.sv ====
// Instruction memory
`timescale 1ns/1ps
`default_nettype none

module progMem #(
  parameter int progDepth = 256
) (
  input  logic         clock,
  input  logic         we,
  input  cpuPkg::wordT wrAddr,
  input  cpuPkg::wordT wrData,
  input  cpuPkg::wordT rdAddr,
  input  logic         fetch,
  output cpuPkg::wordT instr
);
  import cpuPkg::*;

  localparam int addrW = $clog2(progDepth);

  wordT mem [progDepth];

  always_ff @(posedge clock) begin
    if (we) begin
      mem[wrAddr[addrW-1:0]] <= wrData; // Program port
    end
    if (fetch) begin
      instr <= mem[rdAddr[addrW-1:0]];
    end
  end

endmodule

`default_nettype wire

// ==== regFile.sv ====
// Register file
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic            clock,
  input  logic            rstN,
  input  cpuPkg::regAddrT selA,
  input  cpuPkg::regAddrT selB,
  input  cpuPkg::regAddrT wrAddr,
  input  logic            we,
  input  cpuPkg::wordT    wrData,
  output cpuPkg::wordT    rdA,
  output cpuPkg::wordT    rdB
);
  import cpuPkg::*;

  wordT regs [8];

  always_ff @(posedge clock) begin
    if (!rstN) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Reads see the old value during a write
  assign rdA = regs[selA];
  assign rdB = regs[selB];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbCpu -f build.f -o simCpu \
  && ./obj_dir/simCpu > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log \
  && { echo "Simulation reported failure"; exit 1; } \
  || { echo "Simulation reported no failure"; exit 0; }

// ==== tbCpu.sv ====
// CPU testbench
`timescale 1ns/1ps
`default_nettype none

module tbCpu;
  import cpuPkg::*;

  localparam int progDepth    = 256;
  localparam int dataDepth    = 256;
  localparam int progLen      = 64;  // Words loaded per test
  localparam int numTests     = 4;
  localparam int instrPerTest = 300;
  localparam int clockPeriod  = 40;
  localparam longint watchdogNs = longint'(numTests) * instrPerTest * 4 * clockPeriod
                                + longint'(numTests) * (progLen + 10) * clockPeriod + 2000;

  logic    clock = 1'b0;
  logic    rstN;
  logic    run;
  logic    progWe;
  wordT    progAddr;
  wordT    progData;
  wordT    pc;
  stateT   state;
  logic    regWe;
  regAddrT regAddr;
  wordT    regData;

  // Reference model state
  wordT  mRegs [8];
  flagsT mFlags;
  int    mPc;
  wordT  mDmem [dataDepth];
  wordT  progBuf [progLen];

  int errCount   = 0;
  int checkCount = 0;

  cpuTop #(.progDepth(progDepth), .dataDepth(dataDepth)) DUT (
    .clock, .rstN, .run, .progWe, .progAddr, .progData,
    .pc, .state, .regWe, .regAddr, .regData
  );

  always #(clockPeriod / 2) clock = ~clock;

  initial begin : watchdog
    #(watchdogNs);
    $display("Watchdog expired after %0d ns, the CPU run did not finish", watchdogNs);
    $display("Test failed");
    $finish;
  end

  task automatic checkVal(string name, logic [15:0] expV, logic [15:0] actV);
    checkCount++;
    assert (actV === expV) else begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expV, actV);
      errCount++;
    end
  endtask

  task automatic checkPhase(stateT expState, int expPc);
    checkVal("state", 16'(expState), 16'(state));
    checkVal("pc", 16'(expPc), pc);
  endtask

  // r5 holds data addresses and r6 jump targets
  function automatic regAddrT freeDest();
    regAddrT r;
    r = 3'($urandom_range(0, 5));
    return (r == 3'd5) ? 3'd7 : r;
  endfunction

  function automatic wordT randomInstr(int idx);
    int         kind;
    int         target;
    logic [7:0] off8;
    logic [11:0] off12;
    kind   = $urandom_range(0, 99);
    target = $urandom_range(0, progLen - 1); // Jumps stay inside the program
    off8   = 8'(target - idx);
    off12  = 12'(target - idx);
    if (idx == progLen - 1) begin
      kind = 92; // Last word wraps back
    end
    if (kind < 35) begin
      return {2'b10, freeDest(), 5'($urandom_range(0, 9)), 3'($urandom), 3'($urandom)};
    end else if (kind < 45) begin
      return {2'b01, freeDest(), 11'($urandom)};
    end else if (kind < 50) begin
      return {2'b01, 3'd5, 11'($urandom_range(0, 3))};
    end else if (kind < 55) begin
      return {2'b01, 3'd6, 11'(target)};
    end else if (kind < 63) begin
      return {2'b11, freeDest(), 1'($urandom), 2'b00, 8'($urandom)};
    end else if (kind < 71) begin
      return {2'b10, 3'd0, 5'(aluStore), 3'd5, 3'($urandom)};
    end else if (kind < 79) begin
      return {2'b10, freeDest(), 5'(aluLoad), 3'd5, 3'd0};
    end else if (kind < 91) begin
      // Codes above 4 never jump
      return {2'b00, 1'b0, 1'($urandom), 4'($urandom), off8};
    end else if (kind < 95) begin
      return {2'b00, 2'b10, off12};
    end
    return {2'b00, 2'b11, 1'($urandom), 8'h00, 3'd6}; // Link or register jump
  endfunction

  // Preamble stores to addresses 0 to 3 so that loads never see empty memory
  function automatic void makeProgram();
    for (int i = 0; i < progLen; i++) begin
      if (i < 8) begin
        progBuf[i] = (i % 2 == 0) ? {2'b01, 3'd5, 11'(i / 2)}
                                  : {2'b10, 3'd0, 5'(aluStore), 3'd5, 3'($urandom)};
      end else begin
        progBuf[i] = randomInstr(i);
      end
    end
  endfunction

  function automatic void aluModel(input logic [4:0] op, input wordT a, input wordT b,
                                   output wordT res, output logic cOut, output logic vOut);
    shortint sa;
    shortint sb;
    int      sum;
    sa   = shortint'(a);
    sb   = shortint'(b);
    sum  = 0;
    cOut = 1'b0;
    res  = a;
    case (op)
      aluAdd: begin
        res  = a + b;
        cOut = (32'(a) + 32'(b)) > 32'h0000_FFFF;
        sum  = int'(sa) + int'(sb);
      end
      aluSub: begin
        res  = a - b;
        cOut = a < b; // Borrow
        sum  = int'(sa) - int'(sb);
      end
      aluAnd:   res = a & b;
      aluOr:    res = a | b;
      aluXor:   res = a ^ b;
      aluNot:   res = ~a;
      aluShl: begin
        res  = a << 1;
        cOut = a[15];
      end
      aluShr: begin
        res  = a >> 1;
        cOut = a[0];
      end
      aluPassB: res = b;
      default:  res = a;
    endcase
    vOut = (sum > 32767) || (sum < -32768); // Signed result out of range
  endfunction

  function automatic void modelStep(input wordT w, output logic we, output regAddrT wa,
                                    output wordT wd);
    regAddrT rb;
    wordT    res;
    logic    cOut;
    logic    vOut;
    logic    flagBit;
    int      nextPc;
    int      addr;
    we     = 1'b0;
    wa     = w[13:11];
    wd     = '0;
    rb     = w[2:0];
    addr   = int'(mRegs[w[5:3]]) % dataDepth;
    nextPc = (mPc + 1) % progDepth;
    case (w[15:14])
      2'b10: begin
        if (w[10:6] == aluStore) begin
          mDmem[addr] = mRegs[rb];
        end else if (w[10:6] == aluLoad) begin
          we = 1'b1;
          wd = mDmem[addr];
        end else begin
          aluModel(w[10:6], mRegs[w[5:3]], mRegs[rb], res, cOut, vOut);
          we              = 1'b1;
          wd              = res;
          mFlags.zero     = (res == 16'h0000);
          mFlags.negative = res[15];
          mFlags.carry    = cOut;
          mFlags.overflow = vOut;
        end
      end
      2'b01: begin
        we = 1'b1;
        wd = 16'($signed(w[10:0]));
      end
      2'b11: begin
        we = 1'b1;
        wd = w[10] ? {w[7:0], mRegs[wa][7:0]} : {mRegs[wa][15:8], w[7:0]};
      end
      default: begin
        case (w[11:8])
          4'd0:    flagBit = mFlags.zero;
          4'd1:    flagBit = mFlags.negative;
          4'd2:    flagBit = mFlags.carry;
          4'd3:    flagBit = mFlags.overflow;
          4'd4:    flagBit = 1'b1;
          default: flagBit = 1'b0;
        endcase
        if (w[13] == 1'b0) begin
          if ((w[11:8] <= 4'd4) && (flagBit == w[12])) begin
            nextPc = ((mPc + int'($signed(w[7:0]))) % progDepth + progDepth) % progDepth;
          end
        end else if (w[12] == 1'b0) begin
          nextPc = ((mPc + int'($signed(w[11:0]))) % progDepth + progDepth) % progDepth;
        end else begin
          nextPc = int'(mRegs[rb]) % progDepth; // Register read before the link write
          if (!w[11]) begin
            we = 1'b1;
            wa = 3'd7;
            wd = 16'(mPc + 1);
          end
        end
      end
    endcase
    if (we) begin
      mRegs[wa] = wd;
    end
    mPc = nextPc;
  endfunction

  task automatic runTest(int testNum);
    int      errBefore;
    int      oldPc;
    int      done;
    logic    expWe;
    regAddrT expAddr;
    wordT    expData;
    errBefore = errCount;
    done      = 0;
    makeProgram();
    run  = 1'b0;
    rstN = 1'b0;
    repeat (4) @(negedge clock);
    rstN = 1'b1;
    for (int i = 0; i < 8; i++) begin
      mRegs[i] = '0;
    end
    mFlags = '0;
    mPc    = 0;
    // Program load while idle
    for (int i = 0; i < progLen; i++) begin
      progWe   = 1'b1;
      progAddr = 16'(i);
      progData = progBuf[i];
      @(negedge clock);
      checkPhase(fetchS, 0);
      checkVal("regWe", 16'd0, 16'(regWe));
    end
    progWe = 1'b0;
    run    = 1'b1;
    for (int n = 0; n < instrPerTest; n++) begin
      checkPhase(fetchS, mPc);
      checkVal("regWe", 16'd0, 16'(regWe));
      oldPc = mPc;
      modelStep(progBuf[mPc], expWe, expAddr, expData);
      @(negedge clock);
      checkPhase(decodeS, oldPc);
      checkVal("regWe", 16'd0, 16'(regWe));
      @(negedge clock);
      checkPhase(executeS, oldPc);
      checkVal("regWe", 16'd0, 16'(regWe));
      @(negedge clock);
      checkPhase(writebackS, oldPc); // pc moves only after writeback
      checkVal("regWe", 16'(expWe), 16'(regWe));
      if (expWe) begin
        checkVal("regAddr", 16'(expAddr), 16'(regAddr));
        checkVal("regData", expData, regData);
      end
      @(negedge clock);
      done++;
    end
    checkPhase(fetchS, mPc);
    run = 1'b0;
    $display("Run %0d: %0d instructions, %0d errors", testNum, done, errCount - errBefore);
  endtask

  initial begin
    rstN     = 1'b0;
    run      = 1'b0;
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    void'($urandom(99));
    @(negedge clock);
    for (int t = 1; t <= numTests; t++) begin
      runTest(t);
    end
    $display("Runs %0d, checks %0d, errors %0d", numTests, checkCount, errCount);
    if (errCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
